// ==== hdl/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// cache geometry
// ~~~~~~~~~~~~~~~~~~~~

// byte offset within a 32-byte line
`define CACHE_S_OFFSET 5

`define CACHE_S_INDEX 3    // 8 sets

`define CACHE_ADDR_W 32    // byte address

`define CACHE_WAYS 2       // two-way set associative

`endif

// ==== hdl/mem_pkg.sv ====
`default_nettype none
`include "cache_macros.svh"

package mem_pkg;

    localparam int line_bytes = 2**`CACHE_S_OFFSET;

    // byte address on both memory ports
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;

    typedef logic [8*line_bytes-1:0] line_t;    // whole line
    typedef logic [line_bytes-1:0] mask_t;      // one bit per line byte

endpackage : mem_pkg

`default_nettype wire

// ==== hdl/cache_pkg.sv ====
`default_nettype none
`include "cache_macros.svh"

package cache_pkg;

    localparam int s_tag = `CACHE_ADDR_W - `CACHE_S_INDEX - `CACHE_S_OFFSET;
    localparam int num_sets = 2**`CACHE_S_INDEX;

    // ~~~~~~~~~~~~~~~~~~~~
    // organization types
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [s_tag-1:0] tag_t;
    typedef logic [`CACHE_S_INDEX-1:0] index_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

    typedef way_t [num_sets-1:0] lru_t;    // most recently used way, per set

    // ~~~~~~~~~~~~~~~~~~~~
    // address split
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic tag_t addr_tag(input mem_pkg::addr_t addr);
        return addr[`CACHE_ADDR_W-1 -: s_tag];
    endfunction

    function automatic index_t addr_index(input mem_pkg::addr_t addr);
        return addr[`CACHE_S_OFFSET +: `CACHE_S_INDEX];
    endfunction

endpackage : cache_pkg

`default_nettype wire

// ==== hdl/cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_array #(
    parameter type T = logic,
    parameter int depth = 2**`CACHE_S_INDEX
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  cache_pkg::index_t rindex,
    input  cache_pkg::index_t windex,
    input  T                  din,
    output T                  dout
);

T data [depth];

always_ff @(posedge clk)
begin : array_write
    if (rst)
    begin
        for (int i = 0; i < depth; i++)
        begin
            data[i] <= '0;    // every entry invalid and clean
        end
    end
    else if (load)
    begin
        data[windex] <= din;
    end
end

// read is combinational, a write shows up after the edge
assign dout = data[rindex];

endmodule : cache_array

`default_nettype wire

// ==== hdl/cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_control
(
    input  logic clk,
    input  logic rst,
    input  logic pmem_resp,
    input  logic mem_read,
    input  logic mem_write,
    input  logic hit,
    input  logic dirty,
    output logic set_dirty,
    output logic reset_dirty,
    output logic set_valid,
    output logic load_tag,
    output logic set_lru,
    output logic load_data,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write
);

enum int unsigned {
    STORE,
    LOAD,
    HIT
} state, next_state;

// ~~~~~~~~~~~~~~~~~~~~
// state actions
// ~~~~~~~~~~~~~~~~~~~~

always_comb
begin : state_actions
    set_dirty = 1'b0;
    reset_dirty = 1'b0;
    set_valid = 1'b0;
    load_tag = 1'b0;
    set_lru = 1'b0;
    load_data = 1'b0;
    mem_resp = 1'b0;
    pmem_read = 1'b0;
    pmem_write = 1'b0;
    unique case (state)
        LOAD:
        begin
            pmem_read = 1'b1;           // held through the resp cycle
            load_tag = pmem_resp;
            load_data = pmem_resp;      // fill the victim way
            set_valid = pmem_resp;
        end
        STORE:
        begin
            pmem_write = 1'b1;
            reset_dirty = pmem_resp;    // victim now clean
        end
        HIT:
        begin
            mem_resp = (mem_read || mem_write) && hit;
            set_lru = (mem_read || mem_write) && hit;
            set_dirty = mem_write && hit;
            load_data = mem_write && hit;    // byte merge into hit way
        end
        default:;
    endcase
end

// ~~~~~~~~~~~~~~~~~~~~
// next state
// ~~~~~~~~~~~~~~~~~~~~

always_comb
begin : next_state_logic
    next_state = state;
    unique case (state)
        LOAD:
        begin
            if (pmem_resp)
                next_state = HIT;
        end
        STORE:
        begin
            if (pmem_resp)
                next_state = LOAD;
        end
        HIT:
        begin
            if ((mem_read || mem_write) && !hit)
                next_state = dirty ? STORE : LOAD;    // write back first if needed
        end
        default:
        begin
            next_state = HIT;
        end
    endcase
end

always_ff @(posedge clk)
begin : next_state_assignment
    if (rst)
        state <= HIT;
    else
        state <= next_state;
end

a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write))
    else $error("pmem_read and pmem_write high together");

a_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
    mem_resp |-> (mem_read ^ mem_write))
    else $error("mem_resp without exactly one processor request");

endmodule : cache_control

`default_nettype wire

// ==== hdl/cache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_datapath
(
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::addr_t mem_address,
    input  mem_pkg::line_t mem_wdata,
    input  mem_pkg::mask_t mem_byte_enable,
    output mem_pkg::line_t mem_rdata,
    input  mem_pkg::line_t pmem_rdata,
    output mem_pkg::line_t pmem_wdata,
    output mem_pkg::addr_t pmem_address,
    input  logic           set_dirty,
    input  logic           reset_dirty,
    input  logic           set_valid,
    input  logic           load_tag,
    input  logic           set_lru,
    input  logic           load_data,
    output logic           hit,
    output logic           dirty
);

import mem_pkg::*;
import cache_pkg::*;

tag_t   tag;
index_t index;
tag_t   tag_out   [`CACHE_WAYS];
line_t  data_out  [`CACHE_WAYS];
logic   valid_out [`CACHE_WAYS];
logic   dirty_out [`CACHE_WAYS];
logic [`CACHE_WAYS-1:0] way_hit;
way_t   hit_way;
way_t   victim;
lru_t   lru_q;
line_t  hit_line;
line_t  merged;
line_t  data_in;

assign tag = addr_tag(mem_address);
assign index = addr_index(mem_address);

// ~~~~~~~~~~~~~~~~~~~~
// ways
// ~~~~~~~~~~~~~~~~~~~~

for (genvar w = 0; w < `CACHE_WAYS; w++)
begin : g_way
    logic fill_sel;
    logic data_load;
    logic dirty_load;

    assign fill_sel = (victim == way_t'(w));
    assign way_hit[w] = valid_out[w] && (tag_out[w] == tag);
    assign data_load = load_data && (hit ? way_hit[w] : fill_sel);
    assign dirty_load = (set_dirty && way_hit[w]) || (reset_dirty && fill_sel);

    cache_array #(.T(tag_t)) tag_array (
        .clk(clk), .rst(rst), .load(load_tag && fill_sel),
        .rindex(index), .windex(index), .din(tag), .dout(tag_out[w])
    );

    cache_array #(.T(line_t)) data_array (
        .clk(clk), .rst(rst), .load(data_load),
        .rindex(index), .windex(index), .din(data_in), .dout(data_out[w])
    );

    cache_array #(.T(logic)) valid_array (
        .clk(clk), .rst(rst), .load(set_valid && fill_sel),
        .rindex(index), .windex(index), .din(1'b1), .dout(valid_out[w])
    );

    cache_array #(.T(logic)) dirty_array (
        .clk(clk), .rst(rst), .load(dirty_load),
        .rindex(index), .windex(index), .din(set_dirty), .dout(dirty_out[w])
    );
end

assign hit = |way_hit;

always_comb
begin : hit_encode
    hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
        if (way_hit[w])
            hit_way = way_t'(w);
    end
end

assign victim = ~lru_q[index];    // the way not used last
assign dirty = valid_out[victim] && dirty_out[victim];

assign hit_line = data_out[hit_way];
assign mem_rdata = hit_line;

always_comb
begin : byte_merge
    for (int b = 0; b < $bits(mask_t); b++)
    begin
        merged[8*b +: 8] = mem_byte_enable[b] ? mem_wdata[8*b +: 8] : hit_line[8*b +: 8];
    end
end

assign data_in = hit ? merged : pmem_rdata;    // write hit or line fill

// write-back address while the victim is still dirty
assign pmem_wdata = data_out[victim];
assign pmem_address = {dirty ? tag_out[victim] : tag, index, {`CACHE_S_OFFSET{1'b0}}};

always_ff @(posedge clk)
begin : lru_update
    if (rst)
        lru_q <= '0;
    else if (set_lru)
        lru_q[index] <= hit_way;
end

a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
    else $error("both ways hit the same address");

// control must have written back the victim before a fill replaces it
a_fill_clean: assert property (@(posedge clk) disable iff (rst) load_tag |-> !dirty)
    else $error("fill over a dirty victim");

endmodule : cache_datapath

`default_nettype wire

// ==== hdl/cache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache
(
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_read,
    input  logic           mem_write,
    input  mem_pkg::addr_t mem_address,
    input  mem_pkg::line_t mem_wdata,
    input  mem_pkg::mask_t mem_byte_enable,
    output mem_pkg::line_t mem_rdata,
    output logic           mem_resp,
    output logic           pmem_read,
    output logic           pmem_write,
    output mem_pkg::addr_t pmem_address,
    output mem_pkg::line_t pmem_wdata,
    input  mem_pkg::line_t pmem_rdata,
    input  logic           pmem_resp
);

logic hit;
logic dirty;
logic set_dirty;
logic reset_dirty;
logic set_valid;
logic load_tag;
logic set_lru;
logic load_data;

cache_control control (
    .clk(clk), .rst(rst), .pmem_resp(pmem_resp),
    .mem_read(mem_read), .mem_write(mem_write),
    .hit(hit), .dirty(dirty),
    .set_dirty(set_dirty), .reset_dirty(reset_dirty), .set_valid(set_valid),
    .load_tag(load_tag), .set_lru(set_lru), .load_data(load_data),
    .mem_resp(mem_resp), .pmem_read(pmem_read), .pmem_write(pmem_write)
);

cache_datapath datapath (
    .clk(clk), .rst(rst),
    .mem_address(mem_address), .mem_wdata(mem_wdata),
    .mem_byte_enable(mem_byte_enable), .mem_rdata(mem_rdata),
    .pmem_rdata(pmem_rdata), .pmem_wdata(pmem_wdata), .pmem_address(pmem_address),
    .set_dirty(set_dirty), .reset_dirty(reset_dirty), .set_valid(set_valid),
    .load_tag(load_tag), .set_lru(set_lru), .load_data(load_data),
    .hit(hit), .dirty(dirty)
);

endmodule : cache

`default_nettype wire

// ==== verif/pmem_model.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module pmem_model #(
    parameter int latency = 4,
    parameter int num_lines = 64
)
(
    input  logic           clk,
    input  logic           rst,
    input  logic           pmem_read,
    input  logic           pmem_write,
    input  mem_pkg::addr_t pmem_address,
    input  mem_pkg::line_t pmem_wdata,
    output mem_pkg::line_t pmem_rdata,
    output logic           pmem_resp
);

import mem_pkg::*;

line_t mem [num_lines];
int count;
int line_sel;

function automatic logic [7:0] fill_byte(input int a);
    int v;
    v = a * 37 + (a >> 5) * 11;    // mixes byte and line number
    return v[7:0];
endfunction

assign line_sel = int'(pmem_address[`CACHE_S_OFFSET +: $clog2(num_lines)]);

always_ff @(posedge clk)
begin : respond
    if (rst)
    begin
        count <= 0;
        pmem_resp <= 1'b0;
        pmem_rdata <= '0;
        for (int l = 0; l < num_lines; l++)
        begin
            for (int b = 0; b < line_bytes; b++)
                mem[l][8*b +: 8] <= fill_byte(l * line_bytes + b);
        end
    end
    else
    begin
        pmem_resp <= 1'b0;    // one cycle only
        if ((pmem_read || pmem_write) && !pmem_resp)
        begin
            if (count == latency - 1)
            begin
                count <= 0;
                pmem_resp <= 1'b1;
                if (pmem_read)
                    pmem_rdata <= mem[line_sel];
                else
                    mem[line_sel] <= pmem_wdata;
            end
            else
                count <= count + 1;
        end
    end
end

endmodule : pmem_model

`default_nettype wire

// ==== verif/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_tb;

import mem_pkg::*;

localparam int pmem_latency = 4;
localparam int reset_cycles = 8;
localparam int num_random = 200;
localparam int num_accesses = 16 + num_random + 16;
localparam int access_cycles = 2 * (pmem_latency + 1) + 4;    // dirty miss, worst case
localparam int timeout_ns = 10 * (reset_cycles + num_accesses * access_cycles + 200);

logic  clk;
logic  rst;
logic  mem_read;
logic  mem_write;
logic  mem_resp;
logic  pmem_read;
logic  pmem_write;
logic  pmem_resp;
addr_t mem_address;
addr_t pmem_address;
line_t mem_wdata;
line_t mem_rdata;
line_t pmem_wdata;
line_t pmem_rdata;
mask_t mem_byte_enable;

logic [7:0] shadow [64*line_bytes];
integer seed;
int errors;
int checks;
int reads;
int writes;
addr_t wb_addr;
line_t wb_data;

cache DUT (
    .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
    .mem_address(mem_address), .mem_wdata(mem_wdata), .mem_byte_enable(mem_byte_enable),
    .mem_rdata(mem_rdata), .mem_resp(mem_resp), .pmem_read(pmem_read),
    .pmem_write(pmem_write), .pmem_address(pmem_address), .pmem_wdata(pmem_wdata),
    .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
);

pmem_model #(.latency(pmem_latency)) pmem (
    .clk(clk), .rst(rst), .pmem_read(pmem_read), .pmem_write(pmem_write),
    .pmem_address(pmem_address), .pmem_wdata(pmem_wdata),
    .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
);

initial
begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

initial
begin : watchdog
    #(timeout_ns);
    $display("watchdog: the cache stopped answering, run ended after %0d ns", timeout_ns);
    $display("Simulation failed");
    $finish;
end

// physical transactions complete on their resp cycle
always @(negedge clk)
begin
    if (pmem_resp && pmem_read)
        reads++;
    if (pmem_resp && pmem_write)
    begin
        writes++;
        wb_addr = pmem_address;
        wb_data = pmem_wdata;
    end
end

// ~~~~~~~~~~~~~~~~~~~~
// helpers
// ~~~~~~~~~~~~~~~~~~~~

function automatic logic [7:0] pattern_byte(input int a);
    int v;
    v = a * 37 + (a >> 5) * 11;
    return v[7:0];
endfunction

function automatic addr_t make_addr(input int tag, input int set);
    return addr_t'(tag * 256 + set * 32);
endfunction

function automatic int shadow_base(input addr_t a);
    return line_bytes * int'(a[`CACHE_S_OFFSET +: 6]);
endfunction

function automatic line_t shadow_line(input addr_t a);
    line_t l;
    for (int b = 0; b < line_bytes; b++)
        l[8*b +: 8] = shadow[shadow_base(a) + b];
    return l;
endfunction

function automatic line_t random_line();
    line_t l;
    for (int i = 0; i < 8; i++)
        l[32*i +: 32] = $random(seed);
    return l;
endfunction

task automatic access(input logic wr, input addr_t a, input line_t wd, input mask_t m,
                      output line_t rd);
    @(posedge clk);
    #1;
    mem_read = !wr;
    mem_write = wr;
    mem_address = a;
    mem_wdata = wd;
    mem_byte_enable = m;
    @(negedge clk);
    while (!mem_resp)
        @(negedge clk);
    rd = mem_rdata;
    @(posedge clk);
    #1;
    mem_read = 1'b0;
    mem_write = 1'b0;
endtask

task automatic check_line(input line_t got, input addr_t a, input string what);
    line_t exp;
    exp = shadow_line(a);
    checks++;
    assert (got == exp)
    else
    begin
        errors++;
        $display("[ERROR] %0t: %s at %h\n  got      %h\n  expected %h", $time, what, a, got, exp);
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    checks++;
    assert (got == exp)
    else
    begin
        errors++;
        $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic expect_strobes(input int r0, input int w0, input int dr, input int dw,
                              input string what);
    check_count(reads - r0, dr, {what, " pmem_read count"});
    check_count(writes - w0, dw, {what, " pmem_write count"});
endtask

task automatic read_check(input addr_t a, input string what);
    line_t rd;
    access(1'b0, a, '0, '0, rd);
    check_line(rd, a, what);
endtask

task automatic write_merge(input addr_t a, input line_t wd, input mask_t m);
    line_t rd;
    access(1'b1, a, wd, m, rd);
    for (int b = 0; b < line_bytes; b++)
    begin
        if (m[b])
            shadow[shadow_base(a) + b] = wd[8*b +: 8];    // byte merge rule
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~
// tests
// ~~~~~~~~~~~~~~~~~~~~

task automatic test_miss_then_hit();
    addr_t a;
    int r0;
    int w0;
    a = make_addr(1, 1);
    r0 = reads;
    w0 = writes;
    read_check(a, "first read");
    expect_strobes(r0, w0, 1, 0, "read miss");
    read_check(a, "second read");
    expect_strobes(r0, w0, 1, 0, "read hit");
endtask

task automatic test_masked_write();
    addr_t a;
    int r0;
    int w0;
    a = make_addr(2, 2);
    read_check(a, "fill before write");
    r0 = reads;
    w0 = writes;
    write_merge(a, random_line(), $random(seed));
    read_check(a, "merged read");
    expect_strobes(r0, w0, 0, 0, "write hit");
endtask

task automatic test_dirty_eviction();
    addr_t a;
    int r0;
    int w0;
    a = make_addr(1, 3);
    write_merge(a, random_line(), $random(seed));
    read_check(make_addr(2, 3), "second tag");
    r0 = reads;
    w0 = writes;
    read_check(make_addr(3, 3), "third tag");
    expect_strobes(r0, w0, 1, 1, "dirty eviction");
    checks++;
    assert (wb_addr == a)
    else
    begin
        errors++;
        $display("[ERROR] %0t: write-back address %h, expected %h", $time, wb_addr, a);
    end
    check_line(wb_data, a, "write-back data");
    read_check(a, "evicted line");
endtask

task automatic test_lru_order();
    addr_t a;
    addr_t b;
    int r0;
    int w0;
    a = make_addr(1, 4);
    b = make_addr(2, 4);
    read_check(a, "lru A");
    read_check(b, "lru B");
    r0 = reads;
    w0 = writes;
    read_check(a, "lru A again");
    expect_strobes(r0, w0, 0, 0, "A reuse");
    read_check(make_addr(3, 4), "lru C");
    expect_strobes(r0, w0, 1, 0, "C fill");
    read_check(a, "lru A kept");
    expect_strobes(r0, w0, 1, 0, "A after C");
    read_check(b, "lru B evicted");
    expect_strobes(r0, w0, 2, 0, "B after C");
endtask

task automatic test_random_mix();
    addr_t a;
    for (int i = 0; i < num_random; i++)
    begin
        a = make_addr($random(seed) & 3, $random(seed) & 3);    // 4 tags over 4 sets
        if ($random(seed) & 1)
            write_merge(a, random_line(), $random(seed));
        else
            read_check(a, "random read");
    end
    for (int t = 0; t < 4; t++)
    begin
        for (int s = 0; s < 4; s++)
            read_check(make_addr(t, s), "read back");
    end
endtask

initial
begin : main
    seed = 41136;
    errors = 0;
    checks = 0;
    reads = 0;
    writes = 0;
    wb_addr = '0;
    wb_data = '0;
    rst = 1'b1;
    mem_read = 1'b0;
    mem_write = 1'b0;
    mem_address = '0;
    mem_wdata = '0;
    mem_byte_enable = '0;
    for (int i = 0; i < 64 * line_bytes; i++)
        shadow[i] = pattern_byte(i);
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;

    test_miss_then_hit();
    test_masked_write();
    test_dirty_eviction();
    test_lru_order();
    test_random_mix();

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0)
        $display("Simulation completed successfully");
    else
        $display("Simulation failed");
    $finish;
end

endmodule : cache_tb

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/mem_pkg.sv
hdl/cache_pkg.sv
hdl/cache_array.sv
hdl/cache_control.sv
hdl/cache_datapath.sv
hdl/cache.sv
verif/pmem_model.sv
verif/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cache_tb -f files.f

out=$(./obj_dir/Vcache_tb)
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
